/* verilog/rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define XLEN        32
`define INST_ID_W   6
`define RESET_PC    32'h0000_0000

// major opcodes
`define OPCODE_LUI      7'b0110111
`define OPCODE_AUIPC    7'b0010111
`define OPCODE_JAL      7'b1101111
`define OPCODE_JALR     7'b1100111
`define OPCODE_BRANCH   7'b1100011
`define OPCODE_LOAD     7'b0000011
`define OPCODE_STORE    7'b0100011
`define OPCODE_OP_IMM   7'b0010011
`define OPCODE_OP       7'b0110011
`define OPCODE_SYSTEM   7'b1110011

// branches
`define FUNCT3_BEQ      3'b000
`define FUNCT3_BNE      3'b001
`define FUNCT3_BLT      3'b100
`define FUNCT3_BGE      3'b101
`define FUNCT3_BLTU     3'b110
`define FUNCT3_BGEU     3'b111

// loads and stores
`define FUNCT3_LB       3'b000
`define FUNCT3_LH       3'b001
`define FUNCT3_LW       3'b010
`define FUNCT3_LBU      3'b100
`define FUNCT3_LHU      3'b101
`define FUNCT3_SB       3'b000
`define FUNCT3_SH       3'b001
`define FUNCT3_SW       3'b010

// alu ops shared by OP and OP_IMM
`define FUNCT3_ADD      3'b000
`define FUNCT3_SLL      3'b001
`define FUNCT3_SLT      3'b010
`define FUNCT3_SLTU     3'b011
`define FUNCT3_XOR      3'b100
`define FUNCT3_SRL      3'b101
`define FUNCT3_OR       3'b110
`define FUNCT3_AND      3'b111

// system
`define FUNCT3_PRIV     3'b000
`define FUNCT3_CSRRW    3'b001
`define FUNCT3_CSRRS    3'b010
`define FUNCT3_CSRRC    3'b011
`define FUNCT3_CSRRWI   3'b101
`define FUNCT3_CSRRSI   3'b110
`define FUNCT3_CSRRCI   3'b111

`define IMM12_ECALL     12'h000
`define IMM12_EBREAK    12'h001
`define IMM12_MRET      12'h302

`define CSR_ADDR_MEPC   12'h341

`endif

/* verilog/rv_pkg.sv */
`include "rv_defs.svh"

package rv_pkg;

    typedef enum logic [`INST_ID_W-1:0] {
        ID_NONE = 0,
        ID_LUI, ID_AUIPC,
        ID_JAL, ID_JALR,
        ID_BEQ, ID_BNE, ID_BLT, ID_BGE, ID_BLTU, ID_BGEU,
        ID_LB, ID_LH, ID_LW, ID_LBU, ID_LHU,
        ID_SB, ID_SH, ID_SW,
        ID_ADDI, ID_SLTI, ID_SLTIU, ID_XORI, ID_ORI, ID_ANDI,
        ID_SLLI, ID_SRLI, ID_SRAI,
        ID_ADD, ID_SUB, ID_SLL, ID_SLT, ID_SLTU,
        ID_XOR, ID_SRL, ID_SRA, ID_OR, ID_AND,
        ID_ECALL, ID_EBREAK, ID_MRET,
        ID_CSRRW, ID_CSRRS, ID_CSRRC,
        ID_CSRRWI, ID_CSRRSI, ID_CSRRCI
    } inst_id_e;

    // word as it comes off the bus
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        inst_id_e         inst_id;
        logic [6:0]       opcode;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [4:0]       rd;
        logic             rs1_vld;
        logic             rs2_vld;
        logic             rd_vld;
        logic [`XLEN-1:0] imm;    // sign extended
        logic [11:0]      csr;
    } dec_pkt_t;

endpackage

/* verilog/stage_reg.sv */
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    // accept when empty or when drained this cycle
    assign in_ready  = ~valid_q | out_ready;
    assign out_valid = valid_q;
    assign out_data  = data_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;    // flush beats a new load
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

/* verilog/inst_fetch.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module inst_fetch
    import rv_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,
    // wishbone master
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic [`XLEN-1:0] wb_adr,
    input  logic [31:0]      wb_dat_i,
    input  logic             wb_ack,
    // jal redirect from decode
    input  logic             redir_vld,
    input  logic [`XLEN-1:0] redir_pc,
    // to fs
    output logic             out_valid,
    input  logic             out_ready,
    output fetch_pkt_t       out_pkt
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUS,
        S_DROP     // cycle still open but its word is stale
    } state_e;

    state_e           state_q;
    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] adr_q;    // held for the whole bus cycle
    logic             open_cyc;

    // fs only fills from here, so it is still free when the ack comes
    assign open_cyc = (state_q == S_IDLE) && out_ready;

    assign wb_cyc = (state_q != S_IDLE);
    assign wb_stb = (state_q != S_IDLE);
    assign wb_adr = adr_q;

    assign out_valid    = (state_q == S_BUS) && wb_ack;
    assign out_pkt.pc   = adr_q;
    assign out_pkt.inst = wb_dat_i;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (open_cyc) begin
                        state_q <= S_BUS;
                    end
                end
                S_BUS: begin
                    if (wb_ack) begin
                        state_q <= S_IDLE;
                    end else if (redir_vld) begin
                        state_q <= S_DROP;
                    end
                end
                S_DROP: begin
                    if (wb_ack) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= `RESET_PC;
        end else if (redir_vld) begin
            pc_q <= redir_pc;
        end else if (out_valid && out_ready) begin
            pc_q <= pc_q + `XLEN'd4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            adr_q <= `RESET_PC;
        end else if (open_cyc) begin
            adr_q <= redir_vld ? redir_pc : pc_q;    // redirect can land on the open edge
        end
    end

endmodule

/* verilog/inst_decode.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module inst_decode
    import rv_pkg::*;
(
    input  logic             in_valid,
    input  fetch_pkt_t       in_pkt,
    output logic             in_ready,
    output logic             out_valid,
    input  logic             out_ready,
    output dec_pkt_t         out_pkt,
    output logic             redir_vld,
    output logic [`XLEN-1:0] redir_pc
);

    logic [31:0]      inst;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    inst_id_e         inst_id;
    logic [2:0]       vld;      // rs1, rs2, rd
    logic [`XLEN-1:0] imm;
    logic [11:0]      csr;

    assign inst   = in_pkt.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'd0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        inst_id = ID_NONE;
        vld     = 3'b000;
        imm     = '0;
        csr     = 12'd0;
        case (opcode)
            `OPCODE_LUI: begin
                inst_id = ID_LUI;
                vld     = 3'b001;
                imm     = imm_u;
            end
            `OPCODE_AUIPC: begin
                inst_id = ID_AUIPC;
                vld     = 3'b001;
                imm     = imm_u;
            end
            `OPCODE_JAL: begin
                inst_id = ID_JAL;
                vld     = 3'b001;
                imm     = imm_j;
            end
            `OPCODE_JALR: begin
                inst_id = ID_JALR;
                vld     = 3'b101;
                imm     = imm_i;
            end
            `OPCODE_BRANCH: begin
                vld = 3'b110;
                imm = imm_b;
                case (funct3)
                    `FUNCT3_BEQ:  inst_id = ID_BEQ;
                    `FUNCT3_BNE:  inst_id = ID_BNE;
                    `FUNCT3_BLT:  inst_id = ID_BLT;
                    `FUNCT3_BGE:  inst_id = ID_BGE;
                    `FUNCT3_BLTU: inst_id = ID_BLTU;
                    `FUNCT3_BGEU: inst_id = ID_BGEU;
                    default:      inst_id = ID_NONE;
                endcase
            end
            `OPCODE_LOAD: begin
                vld = 3'b101;
                imm = imm_i;
                case (funct3)
                    `FUNCT3_LB:  inst_id = ID_LB;
                    `FUNCT3_LH:  inst_id = ID_LH;
                    `FUNCT3_LW:  inst_id = ID_LW;
                    `FUNCT3_LBU: inst_id = ID_LBU;
                    `FUNCT3_LHU: inst_id = ID_LHU;
                    default:     inst_id = ID_NONE;
                endcase
            end
            `OPCODE_STORE: begin
                vld = 3'b110;
                imm = imm_s;
                case (funct3)
                    `FUNCT3_SB: inst_id = ID_SB;
                    `FUNCT3_SH: inst_id = ID_SH;
                    `FUNCT3_SW: inst_id = ID_SW;
                    default:    inst_id = ID_NONE;
                endcase
            end
            `OPCODE_OP_IMM: begin
                vld = 3'b101;
                imm = imm_i;
                case (funct3)
                    `FUNCT3_ADD:  inst_id = ID_ADDI;
                    `FUNCT3_SLT:  inst_id = ID_SLTI;
                    `FUNCT3_SLTU: inst_id = ID_SLTIU;
                    `FUNCT3_XOR:  inst_id = ID_XORI;
                    `FUNCT3_OR:   inst_id = ID_ORI;
                    `FUNCT3_AND:  inst_id = ID_ANDI;
                    `FUNCT3_SLL:  inst_id = ID_SLLI;
                    default:      inst_id = inst[30] ? ID_SRAI : ID_SRLI;
                endcase
            end
            `OPCODE_OP: begin
                vld = 3'b111;
                case (funct3)
                    `FUNCT3_ADD:  inst_id = inst[30] ? ID_SUB : ID_ADD;
                    `FUNCT3_SLL:  inst_id = ID_SLL;
                    `FUNCT3_SLT:  inst_id = ID_SLT;
                    `FUNCT3_SLTU: inst_id = ID_SLTU;
                    `FUNCT3_XOR:  inst_id = ID_XOR;
                    `FUNCT3_OR:   inst_id = ID_OR;
                    `FUNCT3_AND:  inst_id = ID_AND;
                    default:      inst_id = inst[30] ? ID_SRA : ID_SRL;
                endcase
            end
            `OPCODE_SYSTEM: begin
                vld = 3'b101;
                imm = imm_i;
                csr = inst[31:20];
                case (funct3)
                    `FUNCT3_PRIV: begin
                        vld = 3'b000;
                        case (inst[31:20])
                            `IMM12_ECALL:  inst_id = ID_ECALL;
                            `IMM12_EBREAK: inst_id = ID_EBREAK;
                            `IMM12_MRET: begin
                                inst_id = ID_MRET;
                                csr     = `CSR_ADDR_MEPC;    // return target lives in mepc
                            end
                            default: inst_id = ID_NONE;
                        endcase
                    end
                    `FUNCT3_CSRRW:  inst_id = ID_CSRRW;
                    `FUNCT3_CSRRS:  inst_id = ID_CSRRS;
                    `FUNCT3_CSRRC:  inst_id = ID_CSRRC;
                    `FUNCT3_CSRRWI: inst_id = ID_CSRRWI;
                    `FUNCT3_CSRRSI: inst_id = ID_CSRRSI;
                    `FUNCT3_CSRRCI: inst_id = ID_CSRRCI;
                    default:        inst_id = ID_NONE;
                endcase
            end
            default: inst_id = ID_NONE;
        endcase
        // anything unrecognised claims no registers
        if (inst_id == ID_NONE) begin
            vld = 3'b000;
        end
    end

    assign out_pkt.pc      = in_pkt.pc;
    assign out_pkt.inst_id = inst_id;
    assign out_pkt.opcode  = opcode;
    assign out_pkt.rs1     = inst[19:15];
    assign out_pkt.rs2     = inst[24:20];
    assign out_pkt.rd      = inst[11:7];
    assign out_pkt.rs1_vld = vld[2];
    assign out_pkt.rs2_vld = vld[1];
    assign out_pkt.rd_vld  = vld[0];
    assign out_pkt.imm     = imm;
    assign out_pkt.csr     = csr;

    assign out_valid = in_valid;
    assign in_ready  = out_ready;

    // only once the jal actually moves into ds
    assign redir_vld = in_valid && out_ready && (opcode == `OPCODE_JAL);
    assign redir_pc  = in_pkt.pc + imm_j;

endmodule

/* verilog/rv_frontend.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_frontend
    import rv_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,
    // instruction memory
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output logic [3:0]       wb_sel,
    output logic [`XLEN-1:0] wb_adr,
    input  logic [31:0]      wb_dat_i,
    input  logic             wb_ack,
    // decoded stream
    output logic             out_valid,
    input  logic             out_ready,
    output dec_pkt_t         out_pkt
);

    logic             f_valid;
    logic             f_ready;
    fetch_pkt_t       f_pkt;
    logic             fs_valid;
    logic             fs_ready;
    fetch_pkt_t       fs_pkt;
    logic             d_valid;
    logic             d_ready;
    dec_pkt_t         d_pkt;
    logic             redir_vld;
    logic [`XLEN-1:0] redir_pc;

    assign wb_we  = 1'b0;    // read only
    assign wb_sel = 4'hf;

    inst_fetch fetch0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_adr    (wb_adr),
        .wb_dat_i  (wb_dat_i),
        .wb_ack    (wb_ack),
        .redir_vld (redir_vld),
        .redir_pc  (redir_pc),
        .out_valid (f_valid),
        .out_ready (f_ready),
        .out_pkt   (f_pkt)
    );

    stage_reg #(.payload_t(fetch_pkt_t)) fs0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (redir_vld),    // drop the word behind the jal
        .in_valid  (f_valid),
        .in_data   (f_pkt),
        .in_ready  (f_ready),
        .out_valid (fs_valid),
        .out_ready (fs_ready),
        .out_data  (fs_pkt)
    );

    inst_decode dec0 (
        .in_valid  (fs_valid),
        .in_pkt    (fs_pkt),
        .in_ready  (fs_ready),
        .out_valid (d_valid),
        .out_ready (d_ready),
        .out_pkt   (d_pkt),
        .redir_vld (redir_vld),
        .redir_pc  (redir_pc)
    );

    stage_reg #(.payload_t(dec_pkt_t)) ds0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (1'b0),
        .in_valid  (d_valid),
        .in_data   (d_pkt),
        .in_ready  (d_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_pkt)
    );

endmodule

/* bench/imem_model.sv */
`timescale 1ns/1ps

module imem_model #(
    parameter int DEPTH_LOG2 = 10
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        stall,      // holds off the ack for this cycle
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic [31:0] wb_adr,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack
);

    logic [31:0]           mem [0:(1<<DEPTH_LOG2)-1];    // written by the test
    logic [DEPTH_LOG2-1:0] idx;
    logic                  take;

    assign idx  = wb_adr[DEPTH_LOG2+1:2];
    assign take = wb_cyc && wb_stb && !wb_ack && !stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;    // single beat
        end else if (take) begin
            wb_ack <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            wb_dat_o <= mem[idx];
        end
    end

endmodule

/* bench/tb_rv_frontend.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module tb_rv_frontend
    import rv_pkg::*;
();

    localparam int N_ALU = 19;
    localparam int N_MEM = 17;
    localparam int N_JAL = 10;
    localparam int N_SYS = 9;
    localparam int N_RND = 48;
    localparam int N_BAD = 5;
    localparam int N_ALL = N_ALU + N_MEM + N_JAL + N_SYS + N_RND + N_BAD;
    localparam int WD_CYCLES = 200 * N_ALL + 1000;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        stall;
    logic        out_ready;
    logic        out_valid;
    dec_pkt_t    out_pkt;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_sel;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat;
    logic        wb_ack;

    // program image plus what each word should decode to
    logic [31:0] prog  [0:1023];
    inst_id_e    e_id  [0:1023];
    logic [2:0]  e_vld [0:1023];
    logic [31:0] e_imm [0:1023];
    logic [11:0] e_csr [0:1023];
    int          wr_idx;

    dec_pkt_t    exp_q[$];
    dec_pkt_t    exp_pkt;
    int          err_cnt = 0;
    int          pkt_cnt = 0;
    int          test_cnt = 0;

    always #5 clk = ~clk;

    rv_frontend dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_sel    (wb_sel),
        .wb_adr    (wb_adr),
        .wb_dat_i  (wb_dat),
        .wb_ack    (wb_ack),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pkt   (out_pkt)
    );

    imem_model mem0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .stall    (stall),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr),
        .wb_dat_o (wb_dat),
        .wb_ack   (wb_ack)
    );

    pkt_match: assert property (@(posedge clk) disable iff (!arst_n)
            (out_valid && out_ready) |-> (out_pkt == exp_pkt))
        else begin
            $display("ERR %0t: packet mismatch, expected pc %h id %0d",
                     $time, exp_pkt.pc, exp_pkt.inst_id);
            err_cnt++;
        end

    wb_hold: assert property (@(posedge clk) disable iff (!arst_n)
            (wb_stb && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_adr)))
        else begin
            $display("ERR %0t: wishbone adr or stb changed before ack", $time);
            err_cnt++;
        end

    wb_drop: assert property (@(posedge clk) disable iff (!arst_n)
            (wb_stb && wb_ack) |=> (!wb_cyc && !wb_stb))
        else begin
            $display("ERR %0t: wishbone cyc or stb still high after ack", $time);
            err_cnt++;
        end

    wb_read: assert property (@(posedge clk) disable iff (!arst_n)
            wb_cyc |-> (!wb_we && wb_sel == 4'hf))
        else begin
            $display("ERR %0t: wishbone cycle is not a full word read", $time);
            err_cnt++;
        end

    function automatic logic [31:0] sext(input logic [31:0] v, input int w);
        logic [31:0] r;
        int          b;
        r = v;
        for (b = w; b < 32; b++) begin
            r[b] = v[w-1];
        end
        return r;
    endfunction

    // every unused word is addi x2, x0, <word index>
    task automatic fill_image();
        int i;
        for (i = 0; i < 1024; i++) begin
            prog[i]  = {2'b00, i[9:0], 5'd0, `FUNCT3_ADD, 5'd2, `OPCODE_OP_IMM};
            e_id[i]  = ID_ADDI;
            e_vld[i] = 3'b101;
            e_imm[i] = {22'd0, i[9:0]};
            e_csr[i] = 12'd0;
        end
        wr_idx = 0;
    endtask

    task automatic emit(input logic [31:0] w, input inst_id_e id, input logic [2:0] vld,
                        input logic [31:0] imm, input logic [11:0] csr);
        prog[wr_idx]  = w;
        e_id[wr_idx]  = id;
        e_vld[wr_idx] = vld;
        e_imm[wr_idx] = imm;
        e_csr[wr_idx] = csr;
        wr_idx++;
    endtask

    task automatic put_r(input inst_id_e id, input logic [6:0] f7, input logic [2:0] f3,
                         input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        emit({f7, rs2, rs1, f3, rd, `OPCODE_OP}, id, 3'b111, 32'd0, 12'd0);
    endtask

    task automatic put_i(input inst_id_e id, input logic [6:0] op, input logic [2:0] f3,
                         input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm,
                         input logic [2:0] vld);
        logic [11:0] csr;
        csr = (op == `OPCODE_SYSTEM) ? imm : 12'd0;    // system words carry the csr
        emit({imm, rs1, f3, rd, op}, id, vld, sext(imm, 12), csr);
    endtask

    task automatic put_s(input inst_id_e id, input logic [2:0] f3, input logic [4:0] rs1,
                         input logic [4:0] rs2, input logic [11:0] imm);
        emit({imm[11:5], rs2, rs1, f3, imm[4:0], `OPCODE_STORE}, id, 3'b110,
             sext(imm, 12), 12'd0);
    endtask

    task automatic put_b(input inst_id_e id, input logic [2:0] f3, input logic [4:0] rs1,
                         input logic [4:0] rs2, input logic [12:0] imm);
        emit({imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPCODE_BRANCH},
             id, 3'b110, sext(imm, 13), 12'd0);
    endtask

    task automatic put_u(input inst_id_e id, input logic [6:0] op, input logic [4:0] rd,
                         input logic [19:0] imm);
        emit({imm, rd, op}, id, 3'b001, {imm, 12'd0}, 12'd0);
    endtask

    task automatic put_j(input logic [4:0] rd, input logic [20:0] imm);
        emit({imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPCODE_JAL}, ID_JAL, 3'b001,
             sext(imm, 21), 12'd0);
    endtask

    // walk the image from the reset pc and take every jal
    task automatic predict(input int n);
        logic [31:0] pc;
        logic [31:0] w;
        dec_pkt_t    p;
        int          i;
        int          k;
        exp_q.delete();
        pc = `RESET_PC;
        for (k = 0; k < n; k++) begin
            i         = pc[11:2];
            w         = prog[i];
            p.pc      = pc;
            p.inst_id = e_id[i];
            p.opcode  = w[6:0];
            p.rs1     = w[19:15];
            p.rs2     = w[24:20];
            p.rd      = w[11:7];
            p.rs1_vld = e_vld[i][2];
            p.rs2_vld = e_vld[i][1];
            p.rd_vld  = e_vld[i][0];
            p.imm     = e_imm[i];
            p.csr     = e_csr[i];
            exp_q.push_back(p);
            if (w[6:0] == `OPCODE_JAL) begin
                pc = pc + e_imm[i];
            end else begin
                pc = pc + 32'd4;
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        arst_n    = 1'b0;
        out_ready = 1'b0;
        stall     = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
    endtask

    task automatic run_test(input int num, input string name, input int n, input bit rnd);
        int i;
        int got;
        int errs0;
        bit fire;
        errs0 = err_cnt;
        predict(n);
        for (i = 0; i < 1024; i++) begin
            mem0.mem[i] = prog[i];
        end
        exp_pkt = exp_q.pop_front();
        apply_reset();
        got = 0;
        while (got < n) begin
            @(negedge clk);
            fire = out_valid && out_ready;    // transfer happens on the coming edge
            @(posedge clk);
            #1;
            if (fire) begin
                got++;
                if (exp_q.size() > 0) begin
                    exp_pkt = exp_q.pop_front();
                end
            end
            out_ready = rnd ? ($urandom_range(0, 3) != 0) : 1'b1;
            stall     = rnd ? ($urandom_range(0, 2) == 0) : 1'b0;
        end
        out_ready = 1'b0;
        stall     = 1'b0;
        pkt_cnt  += got;
        test_cnt++;
        $display("test %0d %s: %0d packets, %0d errors", num, name, got, err_cnt - errs0);
    endtask

    task automatic build_alu();
        fill_image();
        put_r(ID_ADD,  7'h00, `FUNCT3_ADD,  5'd1,  5'd2,  5'd3);
        put_r(ID_SUB,  7'h20, `FUNCT3_ADD,  5'd4,  5'd5,  5'd6);
        put_r(ID_SLL,  7'h00, `FUNCT3_SLL,  5'd7,  5'd8,  5'd9);
        put_r(ID_SLT,  7'h00, `FUNCT3_SLT,  5'd10, 5'd11, 5'd12);
        put_r(ID_SLTU, 7'h00, `FUNCT3_SLTU, 5'd13, 5'd14, 5'd15);
        put_r(ID_XOR,  7'h00, `FUNCT3_XOR,  5'd16, 5'd17, 5'd18);
        put_r(ID_SRL,  7'h00, `FUNCT3_SRL,  5'd19, 5'd20, 5'd21);
        put_r(ID_SRA,  7'h20, `FUNCT3_SRL,  5'd22, 5'd23, 5'd24);
        put_r(ID_OR,   7'h00, `FUNCT3_OR,   5'd25, 5'd26, 5'd27);
        put_r(ID_AND,  7'h00, `FUNCT3_AND,  5'd28, 5'd29, 5'd31);
        put_i(ID_ADDI,  `OPCODE_OP_IMM, `FUNCT3_ADD,  5'd1, 5'd2, 12'hfff, 3'b101);
        put_i(ID_SLTI,  `OPCODE_OP_IMM, `FUNCT3_SLT,  5'd3, 5'd4, 12'h800, 3'b101);
        put_i(ID_SLTIU, `OPCODE_OP_IMM, `FUNCT3_SLTU, 5'd5, 5'd6, 12'h7ff, 3'b101);
        put_i(ID_XORI,  `OPCODE_OP_IMM, `FUNCT3_XOR,  5'd7, 5'd8, 12'haaa, 3'b101);
        put_i(ID_ORI,   `OPCODE_OP_IMM, `FUNCT3_OR,   5'd9, 5'd10, 12'h123, 3'b101);
        put_i(ID_ANDI,  `OPCODE_OP_IMM, `FUNCT3_AND,  5'd11, 5'd12, 12'h0f0, 3'b101);
        put_i(ID_SLLI,  `OPCODE_OP_IMM, `FUNCT3_SLL,  5'd13, 5'd14, 12'h01f, 3'b101);
        put_i(ID_SRLI,  `OPCODE_OP_IMM, `FUNCT3_SRL,  5'd15, 5'd16, 12'h005, 3'b101);
        put_i(ID_SRAI,  `OPCODE_OP_IMM, `FUNCT3_SRL,  5'd17, 5'd18, 12'h40c, 3'b101);
    endtask

    task automatic build_mem();
        fill_image();
        put_s(ID_SB, `FUNCT3_SB, 5'd2, 5'd3, 12'h004);
        put_s(ID_SH, `FUNCT3_SH, 5'd4, 5'd5, 12'hffc);
        put_s(ID_SW, `FUNCT3_SW, 5'd6, 5'd7, 12'h7f8);
        put_b(ID_BEQ,  `FUNCT3_BEQ,  5'd1, 5'd2, 13'h0010);
        put_b(ID_BNE,  `FUNCT3_BNE,  5'd3, 5'd4, 13'h1ff0);
        put_b(ID_BLT,  `FUNCT3_BLT,  5'd5, 5'd6, 13'h0ffe);
        put_b(ID_BGE,  `FUNCT3_BGE,  5'd7, 5'd8, 13'h1000);
        put_b(ID_BLTU, `FUNCT3_BLTU, 5'd9, 5'd10, 13'h0802);
        put_b(ID_BGEU, `FUNCT3_BGEU, 5'd11, 5'd12, 13'h07e0);
        put_u(ID_LUI,   `OPCODE_LUI,   5'd5, 20'hfedcb);
        put_u(ID_AUIPC, `OPCODE_AUIPC, 5'd6, 20'h00012);
        put_i(ID_LB,  `OPCODE_LOAD, `FUNCT3_LB,  5'd6,  5'd7,  12'h010, 3'b101);
        put_i(ID_LH,  `OPCODE_LOAD, `FUNCT3_LH,  5'd8,  5'd9,  12'hff0, 3'b101);
        put_i(ID_LW,  `OPCODE_LOAD, `FUNCT3_LW,  5'd10, 5'd11, 12'h000, 3'b101);
        put_i(ID_LBU, `OPCODE_LOAD, `FUNCT3_LBU, 5'd12, 5'd13, 12'h7ff, 3'b101);
        put_i(ID_LHU, `OPCODE_LOAD, `FUNCT3_LHU, 5'd14, 5'd15, 12'h800, 3'b101);
        put_i(ID_JALR, `OPCODE_JALR, 3'b000, 5'd1, 5'd5, 12'h020, 3'b101);
    endtask

    // words 4, 7, 9 and 11 are jumped over
    task automatic build_jal();
        fill_image();
        put_i(ID_ADDI, `OPCODE_OP_IMM, `FUNCT3_ADD, 5'd1, 5'd0, 12'h001, 3'b101);
        put_j(5'd1, 21'd16);
        put_i(ID_ADDI, `OPCODE_OP_IMM, `FUNCT3_ADD, 5'd3, 5'd0, 12'h003, 3'b101);
        put_j(5'd0, 21'd20);
        wr_idx = 5;
        put_i(ID_ADDI, `OPCODE_OP_IMM, `FUNCT3_ADD, 5'd5, 5'd0, 12'h005, 3'b101);
        put_j(5'd0, 21'h1ffff0);    // back to word 2
        wr_idx = 8;
        put_j(5'd0, 21'd8);
        wr_idx = 10;
        put_j(5'd0, 21'd8);
        wr_idx = 12;
        put_i(ID_ADDI, `OPCODE_OP_IMM, `FUNCT3_ADD, 5'd12, 5'd0, 12'h00c, 3'b101);
        put_r(ID_ADD, 7'h00, `FUNCT3_ADD, 5'd13, 5'd12, 5'd1);
    endtask

    task automatic build_sys();
        fill_image();
        put_i(ID_CSRRW,  `OPCODE_SYSTEM, `FUNCT3_CSRRW,  5'd1, 5'd2, 12'h300, 3'b101);
        put_i(ID_CSRRS,  `OPCODE_SYSTEM, `FUNCT3_CSRRS,  5'd3, 5'd4, 12'h341, 3'b101);
        put_i(ID_CSRRC,  `OPCODE_SYSTEM, `FUNCT3_CSRRC,  5'd5, 5'd6, 12'hf14, 3'b101);
        put_i(ID_CSRRWI, `OPCODE_SYSTEM, `FUNCT3_CSRRWI, 5'd7, 5'd5, 12'h305, 3'b101);
        put_i(ID_CSRRSI, `OPCODE_SYSTEM, `FUNCT3_CSRRSI, 5'd8, 5'd9, 12'h7c0, 3'b101);
        put_i(ID_CSRRCI, `OPCODE_SYSTEM, `FUNCT3_CSRRCI, 5'd9, 5'd1, 12'h342, 3'b101);
        put_i(ID_ECALL,  `OPCODE_SYSTEM, `FUNCT3_PRIV, 5'd0, 5'd0, `IMM12_ECALL, 3'b000);
        put_i(ID_EBREAK, `OPCODE_SYSTEM, `FUNCT3_PRIV, 5'd0, 5'd0, `IMM12_EBREAK, 3'b000);
        emit({`IMM12_MRET, 5'd0, `FUNCT3_PRIV, 5'd0, `OPCODE_SYSTEM}, ID_MRET, 3'b000,
             sext(`IMM12_MRET, 12), `CSR_ADDR_MEPC);
    endtask

    // mostly straight code with a forward jal now and then
    task automatic build_rnd();
        logic [31:0] r;
        int          k;
        int          j;
        fill_image();
        for (j = 0; j < 128; j++) begin
            r = $urandom;
            k = $urandom_range(0, 7);
            case (k)
                0: put_r(ID_ADD, 7'h00, `FUNCT3_ADD, r[4:0], r[9:5], r[14:10]);
                1: put_r(ID_SUB, 7'h20, `FUNCT3_ADD, r[4:0], r[9:5], r[14:10]);
                2: put_i(ID_ADDI, `OPCODE_OP_IMM, `FUNCT3_ADD, r[4:0], r[9:5], r[31:20],
                         3'b101);
                3: put_s(ID_SW, `FUNCT3_SW, r[9:5], r[14:10], r[31:20]);
                4: put_b(ID_BNE, `FUNCT3_BNE, r[9:5], r[14:10], {r[31:20], 1'b0});
                5: put_u(ID_LUI, `OPCODE_LUI, r[4:0], r[31:12]);
                6: put_i(ID_LW, `OPCODE_LOAD, `FUNCT3_LW, r[4:0], r[9:5], r[31:20], 3'b101);
                default: put_j(r[4:0], r[15] ? 21'd12 : 21'd8);
            endcase
        end
    endtask

    task automatic build_bad();
        fill_image();
        put_i(ID_ADDI, `OPCODE_OP_IMM, `FUNCT3_ADD, 5'd1, 5'd0, 12'h011, 3'b101);
        emit({25'h1abcdef, 7'b0001011}, ID_NONE, 3'b000, 32'd0, 12'd0);    // custom-0
        put_i(ID_ADDI, `OPCODE_OP_IMM, `FUNCT3_ADD, 5'd2, 5'd1, 12'h022, 3'b101);
        emit(32'hffff_ffff, ID_NONE, 3'b000, 32'd0, 12'd0);
        put_r(ID_ADD, 7'h00, `FUNCT3_ADD, 5'd3, 5'd1, 5'd2);
    endtask

    initial begin
        void'($urandom(38));
        arst_n    = 1'b0;
        out_ready = 1'b0;
        stall     = 1'b0;
        build_alu();
        run_test(1, "alu", N_ALU, 1'b0);
        build_mem();
        run_test(2, "load store branch upper", N_MEM, 1'b0);
        build_jal();
        run_test(3, "jal redirect", N_JAL, 1'b0);
        build_sys();
        run_test(4, "system csr", N_SYS, 1'b0);
        build_rnd();
        run_test(5, "random stall", N_RND, 1'b1);
        build_bad();
        run_test(6, "unknown opcode", N_BAD, 1'b0);
        $display("summary: %0d tests, %0d packets, %0d errors", test_cnt, pkt_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WD_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* tb.f */
+incdir+verilog
verilog/rv_pkg.sv
verilog/stage_reg.sv
verilog/inst_fetch.sv
verilog/inst_decode.sv
verilog/rv_frontend.sv
bench/imem_model.sv
bench/tb_rv_frontend.sv
